// File: vlog.f
src/videoMemPkg.sv
src/dualPortRam.sv
src/cpuBusDecode.sv
src/videoRam.sv
src/lineBuffer.sv
src/cpuResponse.sv
src/videoMemTop.sv
verification/videoMemTb.sv

// File: Bender.yml
package:
  name: video_mem

sources:
  - src/videoMemPkg.sv
  - src/dualPortRam.sv
  - src/cpuBusDecode.sv
  - src/videoRam.sv
  - src/lineBuffer.sv
  - src/cpuResponse.sv
  - src/videoMemTop.sv
  - target: test
    files:
      - verification/videoMemTb.sv

// File: verification/videoMemTb.sv
// videoMemTb: clock, reset, xorshift stimulus, reference model, compare tasks and timeout.
`timescale 1ns/100ps

module videoMemTb;

	import videoMemPkg::*;

	localparam int videoAw = 11;
	localparam int lineAw = 10;
	localparam cpuAddrT workBytes = 13'h0800;
	localparam cpuAddrT videoBytes = 13'h0800;

	// operation counts per test phase; the timeout scales with their sum.
	localparam int cpuOps = 300;
	localparam int stallOps = 300;
	localparam int vidWords = 32;
	localparam int lbWords = 32;
	localparam int lbCollisions = 8;
	localparam int totalOps = cpuOps + stallOps + 3 * vidWords + 3 * lbWords + 3 * lbCollisions;
	localparam int cycleLimit = 4 * totalOps;

	// one outstanding CPU request as the model expects it back.
	typedef struct packed {
		cpuRespT     resp;
		cpuAddrT     addr;
		logic [31:0] cycle;
	} pendingT;

	logic               clk0;
	logic               reset;
	logic               cpuReqValid;
	logic               cpuReqReady;
	cpuReqT             cpuReq;
	logic               cpuRespValid;
	logic               cpuRespReady;
	cpuRespT            cpuResp;
	logic [videoAw-2:0] vidAddr;
	logic [15:0]        vidData;
	logic               lbWrEn;
	logic [lineAw-1:0]  lbWrAddr;
	pixelT              lbWrPixel;
	logic               lbRdEn;
	logic [lineAw-1:0]  lbRdAddr;
	pixelT              lbRdPixel;

	// work and video regions sit back to back, so the low 12 address bits index one model.
	logic [7:0]  cpuModel [4096];
	bit          cpuKnown [4096];
	cpuAddrT     knownAddrs [$];
	pixelT       lbModel [2 ** lineAw];
	pendingT     pending [$];
	cpuReqT      directed [$];
	logic [31:0] rngState;
	int          cycleCount = 0;
	int          toIssue;
	bit          reqHeld;
	bit          vidPending;
	logic [15:0] vidExpected;
	logic [videoAw-2:0] vidCheckAddr;
	bit          lbPending;
	pixelT       lbExpected;
	logic [lineAw-1:0]  lbCheckAddr;

	videoMemTop videoMemTop_i (
		.clk0        (clk0),
		.reset       (reset),
		.cpuReqValid (cpuReqValid),
		.cpuReqReady (cpuReqReady),
		.cpuReq      (cpuReq),
		.cpuRespValid(cpuRespValid),
		.cpuRespReady(cpuRespReady),
		.cpuResp     (cpuResp),
		.vidAddr     (vidAddr),
		.vidData     (vidData),
		.lbWrEn      (lbWrEn),
		.lbWrAddr    (lbWrAddr),
		.lbWrPixel   (lbWrPixel),
		.lbRdEn      (lbRdEn),
		.lbRdAddr    (lbRdAddr),
		.lbRdPixel   (lbRdPixel)
	);

	initial begin
		clk0 = 1'b0;
		forever #4 clk0 = ~clk0;
	end

	task stopWithFailure();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task valueMismatch(input string msg);
		$display("FAILED at time %0t: %s", $time, msg);
		stopWithFailure();
	endtask

	task abortRun(input string msg);
		$display("ERROR: %s", msg);
		stopWithFailure();
	endtask

	always @(posedge clk0) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			abortRun($sformatf("the run timed out after %0d cycles", cycleCount));
		end
	end

	function logic [31:0] xorshift32();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic regionT regionOf(input cpuAddrT a);
		if (a >= WORK_BASE && a < WORK_BASE + workBytes) begin
			return WORK;
		end else if (a >= VIDEO_BASE && a < VIDEO_BASE + videoBytes) begin
			return VIDEO;
		end
		return UNMAPPED;
	endfunction

	// a read of a byte the model has never written moves to a byte it has written,
	// or becomes a write while no byte is known yet.
	function automatic cpuReqT randomReq();
		cpuReqT req;
		logic [31:0] r;
		r = xorshift32();
		case (r[1:0])
			2'd0: req.addr = WORK_BASE + cpuAddrT'(r[12:2]);
			2'd3: req.addr = VIDEO_BASE + videoBytes + cpuAddrT'(r[13:2]);
			default: req.addr = VIDEO_BASE + cpuAddrT'(r[12:2]);
		endcase
		req.write = r[20];
		req.wrData = r[28:21];
		if (!req.write && regionOf(req.addr) != UNMAPPED && !cpuKnown[req.addr[11:0]]) begin
			if (knownAddrs.size() > 0) begin
				req.addr = knownAddrs[xorshift32() % knownAddrs.size()];
			end else begin
				req.write = 1'b1;
			end
		end
		return req;
	endfunction

	task checkCpuResp(input cpuRespT got, input cpuRespT exp, input cpuAddrT addr);
		if (got !== exp) begin
			valueMismatch($sformatf("cpu response for address %h: got %h/%b/%b, expected %h/%b/%b",
				addr, got.rdData, got.err, got.write, exp.rdData, exp.err, exp.write));
		end
	endtask

	task checkVidWord(input logic [15:0] got, input logic [15:0] exp,
		input logic [videoAw-2:0] w);
		if (got !== exp) begin
			valueMismatch($sformatf("video word %h: got %h, expected %h", w, got, exp));
		end
	endtask

	task checkPixel(input pixelT got, input pixelT exp, input logic [lineAw-1:0] a);
		if (got !== exp) begin
			valueMismatch($sformatf("line pixel %h: got %h, expected %h", a, got, exp));
		end
	endtask

	// drive one CPU cycle at the falling edge and resolve the transfers of the next edge.
	task cpuCycle(input bit stalls);
		pendingT entry;
		pendingT head;
		regionT  region;
		@(negedge clk0);
		if (!reqHeld) begin
			if (toIssue > 0 && (directed.size() > 0 || xorshift32() % 8 != 0)) begin
				cpuReq = (directed.size() > 0) ? directed.pop_front() : randomReq();
				cpuReqValid = 1'b1;
			end else begin
				cpuReqValid = 1'b0;
			end
		end
		cpuRespReady = stalls ? (xorshift32() % 4 != 0) : 1'b1;
		// ready and the response come from registers, so they hold until the next edge.
		if (cpuRespValid && cpuRespReady) begin
			if (pending.size() == 0) begin
				abortRun("the DUT returned a response with no request outstanding");
			end
			head = pending.pop_front();
			checkCpuResp(cpuResp, head.resp, head.addr);
			// accepted at the next edge, pushed two edges later, taken one edge after that.
			if (!stalls && cycleCount - int'(head.cycle) != 3) begin
				valueMismatch($sformatf("response for %h came %0d cycles after acceptance",
					head.addr, cycleCount - int'(head.cycle) - 1));
			end
		end
		if (cpuReqValid && cpuReqReady) begin
			region = regionOf(cpuReq.addr);
			entry.resp.write = cpuReq.write;
			entry.resp.err = (region == UNMAPPED);
			entry.resp.rdData = 8'h00;
			if (region == UNMAPPED) begin
				if (!cpuReq.write) entry.resp.rdData = 8'hFF;
			end else if (cpuReq.write) begin
				if (!cpuKnown[cpuReq.addr[11:0]]) knownAddrs.push_back(cpuReq.addr);
				cpuModel[cpuReq.addr[11:0]] = cpuReq.wrData;
				cpuKnown[cpuReq.addr[11:0]] = 1'b1;
			end else begin
				entry.resp.rdData = cpuModel[cpuReq.addr[11:0]];
			end
			entry.addr = cpuReq.addr;
			entry.cycle = cycleCount;
			pending.push_back(entry);
			toIssue--;
		end
		reqHeld = cpuReqValid && !cpuReqReady;
	endtask

	task runCpuPhase(input int numOps, input bit stalls);
		toIssue = numOps;
		while (toIssue > 0 || pending.size() > 0) begin
			cpuCycle(stalls);
		end
	endtask

	task vidStep(input bit fetch, input logic [videoAw-2:0] w);
		@(negedge clk0);
		if (vidPending) checkVidWord(vidData, vidExpected, vidCheckAddr);
		vidAddr = w;
		vidPending = fetch;
		vidCheckAddr = w;
		vidExpected = {cpuModel[int'(VIDEO_BASE) + 2 * int'(w) + 1],
			cpuModel[int'(VIDEO_BASE) + 2 * int'(w)]};
	endtask

	// a read returns the old pixel and clears it; a write on the same edge lands last.
	task lbStep(input bit wr, input logic [lineAw-1:0] wa, input pixelT wp,
		input bit rd, input logic [lineAw-1:0] ra);
		@(negedge clk0);
		if (lbPending) checkPixel(lbRdPixel, lbExpected, lbCheckAddr);
		lbWrEn = wr;
		lbWrAddr = wa;
		lbWrPixel = wp;
		lbRdEn = rd;
		lbRdAddr = ra;
		lbPending = rd;
		lbCheckAddr = ra;
		if (rd) begin
			lbExpected = lbModel[ra];
			lbModel[ra] = '0;
		end
		if (wr) lbModel[wa] = wp;
	endtask

	initial begin
		logic [31:0] r;
		logic [videoAw-2:0] vidList [$];
		logic [lineAw-1:0]  lbList [$];
		cpuReqT req;
		reset = 1'b1;
		cpuReqValid = 1'b0;
		cpuReq = '0;
		cpuRespReady = 1'b0;
		vidAddr = '0;
		lbWrEn = 1'b0;
		lbWrAddr = '0;
		lbWrPixel = '0;
		lbRdEn = 1'b0;
		lbRdAddr = '0;
		rngState = 32'd73791;
		reqHeld = 1'b0;
		vidPending = 1'b0;
		lbPending = 1'b0;
		repeat (5) @(negedge clk0);
		reset = 1'b0;
		if (cpuReqReady !== 1'b1 || cpuRespValid !== 1'b0) begin
			valueMismatch("after reset cpuReqReady must be high and cpuRespValid low");
		end

		runCpuPhase(cpuOps, 1'b0);
		runCpuPhase(stallOps, 1'b1);

		// tile words are written byte by byte over the CPU port, then fetched.
		repeat (vidWords) begin
			r = xorshift32();
			req.write = 1'b1;
			req.addr = VIDEO_BASE + cpuAddrT'({r[9:0], 1'b0});
			req.wrData = r[17:10];
			directed.push_back(req);
			req.addr = VIDEO_BASE + cpuAddrT'({r[9:0], 1'b1});
			req.wrData = r[25:18];
			directed.push_back(req);
			vidList.push_back(r[9:0]);
		end
		runCpuPhase(2 * vidWords, 1'b0);
		foreach (vidList[i]) vidStep(1'b1, vidList[i]);
		vidStep(1'b0, '0);

		repeat (lbWords) begin
			r = xorshift32();
			lbStep(1'b1, r[lineAw-1:0], pixelT'(r[26:16]), 1'b0, '0);
			lbList.push_back(r[lineAw-1:0]);
		end
		foreach (lbList[i]) begin
			lbStep(1'b0, '0, '0, 1'b1, lbList[i]);
			lbStep(1'b0, '0, '0, 1'b1, lbList[i]);
		end
		for (int i = 0; i < lbCollisions; i++) begin
			r = xorshift32();
			lbStep(1'b1, lbList[i], pixelT'(r[10:0]), 1'b1, lbList[i]);
			lbStep(1'b0, '0, '0, 1'b1, lbList[i]);
			lbStep(1'b0, '0, '0, 1'b1, lbList[i]);
		end
		lbStep(1'b0, '0, '0, 1'b0, '0);

		@(negedge clk0);
		if (pending.size() != 0) begin
			abortRun($sformatf("%0d CPU responses never arrived", pending.size()));
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// File: src/videoMemTop.sv
// videoMemTop: arcade memory block with CPU decode, work RAM, video RAM, line buffer and response.
`timescale 1ns/100ps

module videoMemTop #(
	parameter int workAw = 11,
	parameter int videoAw = 11,
	parameter int lineAw = 10
) (
	input  logic                 clk0,
	input  logic                 reset,

	input  logic                 cpuReqValid,
	output logic                 cpuReqReady,
	input  videoMemPkg::cpuReqT  cpuReq,

	output logic                 cpuRespValid,
	input  logic                 cpuRespReady,
	output videoMemPkg::cpuRespT cpuResp,

	input  logic [videoAw-2:0]   vidAddr,
	output logic [15:0]          vidData,

	input  logic                 lbWrEn,
	input  logic [lineAw-1:0]    lbWrAddr,
	input  videoMemPkg::pixelT   lbWrPixel,
	input  logic                 lbRdEn,
	input  logic [lineAw-1:0]    lbRdAddr,
	output videoMemPkg::pixelT   lbRdPixel
);

	import videoMemPkg::*;

	localparam int issueAw = (workAw > videoAw) ? workAw : videoAw;

	logic [1:0]         slotFree;
	logic               issueValid;
	regionT             issueRegion;
	logic               issueWrite;
	logic [issueAw-1:0] issueAddr;
	logic [7:0]         issueData;
	logic [7:0]         workRdData;
	logic [7:0]         videoRdData;

	cpuBusDecode #(
		.workAw (workAw),
		.videoAw(videoAw)
	) cpuBusDecode_i (
		.clk0       (clk0),
		.reset      (reset),
		.cpuReqValid(cpuReqValid),
		.cpuReqReady(cpuReqReady),
		.cpuReq     (cpuReq),
		.slotFree   (slotFree),
		.issueValid (issueValid),
		.issueRegion(issueRegion),
		.issueWrite (issueWrite),
		.issueAddr  (issueAddr),
		.issueData  (issueData)
	);

	// work RAM, CPU access only.
	dualPortRam #(
		.addrWidth(workAw),
		.wordT    (logic [7:0])
	) workRam_i (
		.clk0   (clk0),
		.aAddr  (issueAddr[workAw-1:0]),
		.aWrEn  (issueValid && issueWrite && (issueRegion == WORK)),
		.aWrData(issueData),
		.aRdData(workRdData),
		.bAddr  ('0),
		.bRdData()
	);

	videoRam #(
		.videoAw(videoAw)
	) videoRam_i (
		.clk0     (clk0),
		.cpuEn    (issueValid && (issueRegion == VIDEO)),
		.cpuWrite (issueWrite),
		.cpuAddr  (issueAddr[videoAw-1:0]),
		.cpuWrData(issueData),
		.cpuRdData(videoRdData),
		.vidAddr  (vidAddr),
		.vidData  (vidData)
	);

	lineBuffer #(
		.lineAw(lineAw)
	) lineBuffer_i (
		.clk0   (clk0),
		.wrEn   (lbWrEn),
		.wrAddr (lbWrAddr),
		.wrPixel(lbWrPixel),
		.rdEn   (lbRdEn),
		.rdAddr (lbRdAddr),
		.rdPixel(lbRdPixel)
	);

	cpuResponse cpuResponse_i (
		.clk0        (clk0),
		.reset       (reset),
		.issueValid  (issueValid),
		.issueRegion (issueRegion),
		.issueWrite  (issueWrite),
		.workRdData  (workRdData),
		.videoRdData (videoRdData),
		.slotFree    (slotFree),
		.cpuRespValid(cpuRespValid),
		.cpuRespReady(cpuRespReady),
		.cpuResp     (cpuResp)
	);

endmodule

// File: src/cpuResponse.sv
// cpuResponse: region data select, unmapped tagging and the two-entry CPU response queue.
`timescale 1ns/100ps

module cpuResponse (
	input  logic                 clk0,
	input  logic                 reset,

	input  logic                 issueValid,
	input  videoMemPkg::regionT  issueRegion,
	input  logic                 issueWrite,
	input  logic [7:0]           workRdData,
	input  logic [7:0]           videoRdData,

	output logic [1:0]           slotFree,

	output logic                 cpuRespValid,
	input  logic                 cpuRespReady,
	output videoMemPkg::cpuRespT cpuResp
);

	import videoMemPkg::*;

	logic    memValid;
	regionT  memRegion;
	logic    memWrite;
	cpuRespT newResp;
	cpuRespT queue [2];
	logic    wrPtr;
	logic    rdPtr;
	logic [1:0] count;
	logic    push;
	logic    pop;

	// control travels beside the memory access so it meets the RAM data.
	always_ff @(posedge clk0) begin
		if (reset) begin
			memValid <= 1'b0;
		end else begin
			memValid <= issueValid;
		end
	end

	always_ff @(posedge clk0) begin
		if (issueValid) begin
			memRegion <= issueRegion;
			memWrite <= issueWrite;
		end
	end

	// a write is acknowledged with zero data.
	always_comb begin
		newResp.write = memWrite;
		newResp.err = 1'b0;
		newResp.rdData = '0;
		case (memRegion)
			WORK: begin
				if (!memWrite) newResp.rdData = workRdData;
			end
			VIDEO: begin
				if (!memWrite) newResp.rdData = videoRdData;
			end
			default: begin
				newResp.err = 1'b1;
				if (!memWrite) newResp.rdData = UNMAPPED_DATA;
			end
		endcase
	end

	assign push = memValid;
	assign pop = cpuRespValid && cpuRespReady;

	always_ff @(posedge clk0) begin
		if (reset) begin
			wrPtr <= 1'b0;
			rdPtr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push) wrPtr <= !wrPtr;
			if (pop) rdPtr <= !rdPtr;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk0) begin
		if (push) begin
			queue[wrPtr] <= newResp;
		end
	end

	assign cpuRespValid = count != 2'd0;
	assign cpuResp = queue[rdPtr];

	// the access in the memory stage already owns a slot.
	assign slotFree = 2'd2 - count - {1'b0, memValid};

	// decode credit must keep the queue from being pushed while full.
	queueNoOverflow: assert property (
		@(posedge clk0) disable iff (reset)
		push |-> (count < 2'd2 || pop)
	);

endmodule

// File: src/lineBuffer.sv
// lineBuffer: scanline pixel buffer with a sprite write port and a clear-on-read display port.
`timescale 1ns/100ps

module lineBuffer #(
	parameter int lineAw = 10
) (
	input  logic               clk0,

	// sprite writer.
	input  logic               wrEn,
	input  logic [lineAw-1:0]  wrAddr,
	input  videoMemPkg::pixelT wrPixel,

	// display reader.
	input  logic               rdEn,
	input  logic [lineAw-1:0]  rdAddr,
	output videoMemPkg::pixelT rdPixel
);

	import videoMemPkg::*;

	localparam int depth = 2 ** lineAw;

	pixelT mem [depth];

	// a read fetches the pixel and clears the entry on the same edge,
	// leaving the line transparent for the next scanline.
	// the sprite write comes last so it wins when both hit one address.
	always_ff @(posedge clk0) begin
		if (rdEn) begin
			rdPixel <= mem[rdAddr];
			mem[rdAddr] <= '0;
		end
		if (wrEn) begin
			mem[wrAddr] <= wrPixel;
		end
	end

	// Back-to-back reads of one address, with no write to it at the first edge, must
	// return transparent on the second.
	clearedReadsZero: assert property (
		@(posedge clk0)
		(rdEn && $past(rdEn) && (rdAddr == $past(rdAddr)) &&
			!($past(wrEn) && ($past(wrAddr) == $past(rdAddr))))
		|=> (rdPixel == '0)
	);

endmodule

// File: src/videoRam.sv
// videoRam: byte-wide CPU port and 16-bit video fetch port over even and odd byte banks.
`timescale 1ns/100ps

module videoRam #(
	parameter int videoAw = 11
) (
	input  logic               clk0,

	// CPU side, byte address.
	input  logic               cpuEn,
	input  logic               cpuWrite,
	input  logic [videoAw-1:0] cpuAddr,
	input  logic [7:0]         cpuWrData,
	output logic [7:0]         cpuRdData,

	// video side, word address.
	input  logic [videoAw-2:0] vidAddr,
	output logic [15:0]        vidData
);

	logic       evenWrEn;
	logic       oddWrEn;
	logic       rdOdd;
	logic [7:0] evenCpuRd;
	logic [7:0] oddCpuRd;
	logic [7:0] evenVid;
	logic [7:0] oddVid;

	// bit 0 of the byte address selects the bank.
	assign evenWrEn = cpuEn && cpuWrite && !cpuAddr[0];
	assign oddWrEn = cpuEn && cpuWrite && cpuAddr[0];

	dualPortRam #(
		.addrWidth(videoAw - 1),
		.wordT    (logic [7:0])
	) evenBank_i (
		.clk0   (clk0),
		.aAddr  (cpuAddr[videoAw-1:1]),
		.aWrEn  (evenWrEn),
		.aWrData(cpuWrData),
		.aRdData(evenCpuRd),
		.bAddr  (vidAddr),
		.bRdData(evenVid)
	);

	dualPortRam #(
		.addrWidth(videoAw - 1),
		.wordT    (logic [7:0])
	) oddBank_i (
		.clk0   (clk0),
		.aAddr  (cpuAddr[videoAw-1:1]),
		.aWrEn  (oddWrEn),
		.aWrData(cpuWrData),
		.aRdData(oddCpuRd),
		.bAddr  (vidAddr),
		.bRdData(oddVid)
	);

	// bank select follows the read data by one cycle.
	always_ff @(posedge clk0) begin
		if (cpuEn && !cpuWrite) begin
			rdOdd <= cpuAddr[0];
		end
	end

	assign cpuRdData = rdOdd ? oddCpuRd : evenCpuRd;

	// odd byte is the high half of the tile word.
	assign vidData = {oddVid, evenVid};

endmodule

// File: src/cpuBusDecode.sv
// cpuBusDecode: CPU request acceptance, region classification and the registered issue stage.
`timescale 1ns/100ps

module cpuBusDecode #(
	parameter int workAw = 11,
	parameter int videoAw = 11,
	localparam int issueAw = (workAw > videoAw) ? workAw : videoAw
) (
	input  logic                 clk0,
	input  logic                 reset,

	input  logic                 cpuReqValid,
	output logic                 cpuReqReady,
	input  videoMemPkg::cpuReqT  cpuReq,

	// free response slots, already net of the stage after this one.
	input  logic [1:0]           slotFree,

	output logic                 issueValid,
	output videoMemPkg::regionT  issueRegion,
	output logic                 issueWrite,
	output logic [issueAw-1:0]   issueAddr,
	output logic [7:0]           issueData
);

	import videoMemPkg::*;

	localparam cpuAddrT workSize = cpuAddrT'(1 << workAw);
	localparam cpuAddrT videoSize = cpuAddrT'(1 << videoAw);

	logic    accept;
	cpuAddrT workOff;
	cpuAddrT videoOff;
	regionT  region;
	cpuAddrT regionOff;

	// room is needed for the request in the issue stage as well as the new one.
	assign cpuReqReady = slotFree > {1'b0, issueValid};
	assign accept = cpuReqValid && cpuReqReady;

	// an address below a base wraps to a large offset, so one compare per region is enough.
	assign workOff = cpuReq.addr - WORK_BASE;
	assign videoOff = cpuReq.addr - VIDEO_BASE;

	always_comb begin
		if (workOff < workSize) begin
			region = WORK;
			regionOff = workOff;
		end else if (videoOff < videoSize) begin
			region = VIDEO;
			regionOff = videoOff;
		end else begin
			region = UNMAPPED;
			regionOff = '0;
		end
	end

	always_ff @(posedge clk0) begin
		if (reset) begin
			issueValid <= 1'b0;
		end else begin
			issueValid <= accept;
		end
	end

	always_ff @(posedge clk0) begin
		if (accept) begin
			issueRegion <= region;
			issueWrite <= cpuReq.write;
			issueAddr <= regionOff[issueAw-1:0];
			issueData <= cpuReq.wrData;
		end
	end

	// the CPU must keep a stalled request unchanged until it is taken.
	reqStableWhileStalled: assert property (
		@(posedge clk0) disable iff (reset)
		(cpuReqValid && !cpuReqReady) |=> (cpuReqValid && $stable(cpuReq))
	);

endmodule

// File: src/dualPortRam.sv
// dualPortRam: synchronous storage with a read/write port A and a read-only port B.
`timescale 1ns/100ps

module dualPortRam #(
	parameter int addrWidth = 10,
	parameter type wordT = logic [7:0]
) (
	input  logic                 clk0,

	// port A, write when aWrEn is high, read otherwise.
	input  logic [addrWidth-1:0] aAddr,
	input  logic                 aWrEn,
	input  wordT                 aWrData,
	output wordT                 aRdData,

	// port B, read only.
	input  logic [addrWidth-1:0] bAddr,
	output wordT                 bRdData
);

	localparam int depth = 2 ** addrWidth;

	wordT mem [depth];

	// port A reads only on cycles without a write, so aRdData holds its last read value
	// across a write.
	always_ff @(posedge clk0) begin
		if (aWrEn) begin
			mem[aAddr] <= aWrData;
		end else begin
			aRdData <= mem[aAddr];
		end
	end

	// port B sees a write to the same address one cycle later.
	always_ff @(posedge clk0) begin
		bRdData <= mem[bAddr];
	end

endmodule

// File: src/videoMemPkg.sv
// Shared types and address map for the video memory block: CPU request/response, region, pixel.
package videoMemPkg;

	// 13-bit CPU byte address covers both regions and the unmapped space above them.
	typedef logic [12:0] cpuAddrT;

	// one CPU bus request as it travels on the valid/ready channel.
	typedef struct packed {
		cpuAddrT    addr;
		logic [7:0] wrData;
		logic       write;
	} cpuReqT;

	// region a request falls into after decode.
	typedef enum logic [1:0] {
		WORK     = 2'd0,
		VIDEO    = 2'd1,
		UNMAPPED = 2'd2
	} regionT;

	// one CPU response.
	// err flags an unmapped access, write echoes the request type.
	typedef struct packed {
		logic [7:0] rdData;
		logic       err;
		logic       write;
	} cpuRespT;

	// scanline pixel, an all-zero value is transparent.
	typedef struct packed {
		logic       prio;
		logic [5:0] palette;
		logic [3:0] color;
	} pixelT;

	// region bases.
	// each region spans 2**aw bytes from its base, aw being the width the top level sets.
	localparam cpuAddrT WORK_BASE = 13'h0000;
	localparam cpuAddrT VIDEO_BASE = 13'h0800;

	// value returned for a read of an unmapped address.
	localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

endpackage
